// File: design/cdc_defines.svh
`ifndef CDC_DEFINES_SVH
`define CDC_DEFINES_SVH

// ==================================================
// timing divisors
// ==================================================

// clock cycles per uart bit
`define CDC_UART_DIV 16

// clock cycles per half period of spi_clk
`define CDC_SPI_DIV 4

// number of pwm channels
`define CDC_PWM_CH 8

// ==================================================
// command codes
// ==================================================
`define CDC_CMD_PWM  8'h01
`define CDC_CMD_UART 8'h02
`define CDC_CMD_SPI  8'h03
`define CDC_CMD_DAC  8'h04

`endif

// File: design/cdc_pkg.sv
package cdc_pkg;

    // plain data byte
    typedef logic [7:0] byte_t;

    // pwm duty, 1/256 steps
    typedef logic [7:0] duty_t;

    // pwm channel index
    typedef logic [2:0] chan_t;

    typedef logic [13:0] dac_code_t;

    // command frame decoder
    typedef enum logic [1:0] {
        IDLE, ARG0, ARG1
    } parser_state_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } uart_rx_state_t;

    typedef enum logic [1:0] {
        SPI_IDLE, SPI_LOW, SPI_HIGH, SPI_END
    } spi_state_t;

endpackage

// File: design/cmd_parser.sv
`include "cdc_defines.svh"

module cmd_parser import cdc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  byte_t     usb_data_i,
    input  logic      usb_valid_i,
    output byte_t     upload_data_o,
    output logic      upload_valid_o,
    output dac_code_t dac_data_o,
    output logic      debug_o,
    output logic      duty_we_o,
    output chan_t     duty_chan_o,
    output duty_t     duty_val_o,
    output logic      tx_start_o,
    output byte_t     tx_byte_o,
    input  logic      tx_busy_i,
    output logic      spi_start_o,
    output byte_t     spi_tx_byte_o,
    input  logic      spi_busy_i,
    input  logic      spi_done_i,
    input  byte_t     spi_rx_byte_i,
    input  logic      rx_valid_i,
    input  byte_t     rx_byte_i,
    input  logic      rx_err_i
);
    localparam int CHAN_W = $clog2(`CDC_PWM_CH);

    parser_state_t state;
    byte_t         cmd_q;
    byte_t         arg0_q;
    logic          pend_valid_q;
    byte_t         pend_byte_q;

    // ==================================================
    // frame decoder and dispatch
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            cmd_q       <= '0;
            duty_we_o   <= 1'b0;
            tx_start_o  <= 1'b0;
            spi_start_o <= 1'b0;
            debug_o     <= 1'b0;
            dac_data_o  <= '0;
        end else begin
            // dispatch strobes last one cycle
            duty_we_o   <= 1'b0;
            tx_start_o  <= 1'b0;
            spi_start_o <= 1'b0;
            debug_o     <= rx_err_i;
            if (usb_valid_i) begin
                case (state)
                    IDLE: begin
                        case (usb_data_i)
                            `CDC_CMD_PWM, `CDC_CMD_UART, `CDC_CMD_SPI, `CDC_CMD_DAC: begin
                                cmd_q <= usb_data_i;
                                state <= ARG0;
                            end
                            // unknown command, stay idle
                            default: debug_o <= 1'b1;
                        endcase
                    end
                    ARG0: begin
                        arg0_q <= usb_data_i;
                        state  <= IDLE;
                        case (cmd_q)
                            `CDC_CMD_UART: begin
                                if (tx_busy_i) begin
                                    debug_o <= 1'b1;
                                end else begin
                                    tx_start_o <= 1'b1;
                                    tx_byte_o  <= usb_data_i;
                                end
                            end
                            `CDC_CMD_SPI: begin
                                if (spi_busy_i) begin
                                    debug_o <= 1'b1;
                                end else begin
                                    spi_start_o   <= 1'b1;
                                    spi_tx_byte_o <= usb_data_i;
                                end
                            end
                            // pwm and dac need a second argument
                            default: state <= ARG1;
                        endcase
                    end
                    default: begin
                        state <= IDLE;
                        if (cmd_q == `CDC_CMD_PWM) begin
                            duty_we_o   <= 1'b1;
                            duty_chan_o <= chan_t'(arg0_q[CHAN_W-1:0]);
                            duty_val_o  <= usb_data_i;
                        end else begin
                            dac_data_o <= {arg0_q[5:0], usb_data_i};
                        end
                    end
                endcase
            end
        end
    end

    // ==================================================
    // upload mux, spi result wins a tie
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            upload_valid_o <= 1'b0;
            pend_valid_q   <= 1'b0;
        end else begin
            upload_valid_o <= spi_done_i | pend_valid_q | rx_valid_i;
            if (spi_done_i) begin
                upload_data_o <= spi_rx_byte_i;
                // uart byte parks until the next free cycle
                if (rx_valid_i) begin
                    pend_valid_q <= 1'b1;
                    pend_byte_q  <= rx_byte_i;
                end
            end else if (pend_valid_q) begin
                upload_data_o <= pend_byte_q;
                pend_valid_q  <= rx_valid_i;
                pend_byte_q   <= rx_byte_i;
            end else if (rx_valid_i) begin
                upload_data_o <= rx_byte_i;
            end
        end
    end

endmodule

// File: design/pwm_bank.sv
`include "cdc_defines.svh"

module pwm_bank import cdc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   duty_we_i,
    input  chan_t                  duty_chan_i,
    input  duty_t                  duty_val_i,
    output logic [`CDC_PWM_CH-1:0] pwm_o
);
    duty_t      duty_q [`CDC_PWM_CH];
    logic [7:0] cnt_q;

    // ==================================================
    // shared counter and duty registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                duty_q[i] <= '0;
            end
        end else begin
            // free running, wraps every 256 cycles
            cnt_q <= cnt_q + 1'b1;
            if (duty_we_i) begin
                duty_q[duty_chan_i] <= duty_val_i;
            end
        end
    end

    // high while counter below duty
    // duty 0 never fires, 255 misses one slot per period
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pwm_o <= '0;
        end else begin
            for (int i = 0; i < `CDC_PWM_CH; i++) begin
                pwm_o[i] <= (cnt_q < duty_q[i]);
            end
        end
    end

endmodule

// File: design/uart_bridge.sv
`include "cdc_defines.svh"

module uart_bridge import cdc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  tx_start_i,
    input  byte_t tx_byte_i,
    output logic  tx_busy_o,
    output logic  uart_tx_o,
    input  logic  uart_rx_i,
    output logic  rx_valid_o,
    output byte_t rx_byte_o,
    output logic  rx_err_o
);
    localparam int DIV_W = $clog2(`CDC_UART_DIV);
    // rx counter also spans the half bit after the stop sample
    localparam int RX_W = DIV_W + 1;
    localparam logic [DIV_W-1:0] TX_LAST = DIV_W'(`CDC_UART_DIV - 1);
    localparam logic [RX_W-1:0]  RX_HALF = RX_W'(`CDC_UART_DIV / 2 - 1);
    localparam logic [RX_W-1:0]  RX_FULL = RX_W'(`CDC_UART_DIV - 1);
    localparam logic [RX_W-1:0]  RX_END  = RX_W'(`CDC_UART_DIV + `CDC_UART_DIV / 2 - 1);

    uart_tx_state_t   tx_state;
    logic [DIV_W-1:0] tx_cnt;
    logic [2:0]       tx_bit;
    byte_t            tx_sh;

    uart_rx_state_t   rx_state;
    logic [RX_W-1:0]  rx_cnt;
    logic [2:0]       rx_bit;
    logic             rx_s1;
    logic             rx_s2;
    logic             rx_stop_q;

    // ==================================================
    // transmitter
    // ==================================================
    assign tx_busy_o = (tx_state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tx_state  <= TX_IDLE;
            tx_cnt    <= '0;
            tx_bit    <= '0;
            uart_tx_o <= 1'b1;
        end else if (tx_state == TX_IDLE) begin
            if (tx_start_i) begin
                tx_sh     <= tx_byte_i;
                tx_cnt    <= '0;
                uart_tx_o <= 1'b0;
                tx_state  <= TX_START;
            end
        end else if (tx_cnt != TX_LAST) begin
            tx_cnt <= tx_cnt + 1'b1;
        end else begin
            tx_cnt <= '0;
            case (tx_state)
                TX_START: begin
                    tx_bit    <= '0;
                    uart_tx_o <= tx_sh[0];
                    tx_state  <= TX_DATA;
                end
                TX_DATA: begin
                    if (tx_bit == 3'd7) begin
                        uart_tx_o <= 1'b1;
                        tx_state  <= TX_STOP;
                    end else begin
                        // lsb first
                        tx_bit    <= tx_bit + 1'b1;
                        tx_sh     <= tx_sh >> 1;
                        uart_tx_o <= tx_sh[1];
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // ==================================================
    // receiver
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rx_s1      <= 1'b1;
            rx_s2      <= 1'b1;
            rx_state   <= RX_IDLE;
            rx_cnt     <= '0;
            rx_bit     <= '0;
            rx_valid_o <= 1'b0;
            rx_err_o   <= 1'b0;
        end else begin
            rx_s1      <= uart_rx_i;
            rx_s2      <= rx_s1;
            rx_valid_o <= 1'b0;
            rx_err_o   <= 1'b0;
            rx_cnt     <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_s2) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    // glitch check at mid start bit
                    if (rx_cnt == RX_HALF) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_s2 ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == RX_FULL) begin
                        rx_cnt    <= '0;
                        rx_byte_o <= {rx_s2, rx_byte_o[7:1]};
                        rx_bit    <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (rx_cnt == RX_FULL) begin
                        rx_stop_q <= rx_s2;
                    end
                    if (rx_cnt == RX_END) begin
                        rx_valid_o <= rx_stop_q;
                        rx_err_o   <= !rx_stop_q;
                        rx_state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/spi_master.sv
`include "cdc_defines.svh"

module spi_master import cdc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  start_i,
    input  byte_t tx_byte_i,
    output logic  busy_o,
    output logic  done_o,
    output byte_t rx_byte_o,
    output logic  spi_clk_o,
    output logic  spi_cs_n_o,
    output logic  spi_mosi_o,
    input  logic  spi_miso_i
);
    localparam int CNT_W = $clog2(`CDC_SPI_DIV);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`CDC_SPI_DIV - 1);

    spi_state_t       state;
    logic [CNT_W-1:0] half_cnt;
    logic [2:0]       bit_cnt;
    // mosi leaves the top, miso enters the bottom
    byte_t            sh;

    assign busy_o    = (state != SPI_IDLE);
    assign rx_byte_o = sh;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state      <= SPI_IDLE;
            half_cnt   <= '0;
            bit_cnt    <= '0;
            spi_clk_o  <= 1'b0;
            spi_cs_n_o <= 1'b1;
            spi_mosi_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o   <= 1'b0;
            half_cnt <= half_cnt + 1'b1;
            case (state)
                SPI_IDLE: begin
                    half_cnt <= '0;
                    if (start_i) begin
                        // first bit valid before the first rising edge
                        sh         <= tx_byte_i;
                        spi_mosi_o <= tx_byte_i[7];
                        spi_cs_n_o <= 1'b0;
                        bit_cnt    <= '0;
                        state      <= SPI_LOW;
                    end
                end
                SPI_LOW: begin
                    if (half_cnt == HALF_LAST) begin
                        spi_clk_o <= 1'b1;
                        sh        <= {sh[6:0], spi_miso_i};
                        state     <= SPI_HIGH;
                    end
                end
                SPI_HIGH: begin
                    if (half_cnt == HALF_LAST) begin
                        spi_clk_o <= 1'b0;
                        if (bit_cnt == 3'd7) begin
                            state <= SPI_END;
                        end else begin
                            bit_cnt    <= bit_cnt + 1'b1;
                            spi_mosi_o <= sh[7];
                            state      <= SPI_LOW;
                        end
                    end
                end
                default: begin
                    // cs hold time of one half period
                    if (half_cnt == HALF_LAST) begin
                        spi_cs_n_o <= 1'b1;
                        spi_mosi_o <= 1'b0;
                        done_o     <= 1'b1;
                        state      <= SPI_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/cdc_ctrl_top.sv
`include "cdc_defines.svh"

module cdc_ctrl_top import cdc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  byte_t                  usb_data_i,
    input  logic                   usb_valid_i,
    output byte_t                  upload_data_o,
    output logic                   upload_valid_o,
    output logic [`CDC_PWM_CH-1:0] pwm_o,
    input  logic                   uart_rx_i,
    output logic                   uart_tx_o,
    output logic                   spi_clk_o,
    output logic                   spi_cs_n_o,
    output logic                   spi_mosi_o,
    input  logic                   spi_miso_i,
    output dac_code_t              dac_data_o,
    output logic                   debug_o
);
    // pwm dispatch
    logic  duty_we;
    chan_t duty_chan;
    duty_t duty_val;

    // uart bridge
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_busy;
    logic  rx_valid;
    byte_t rx_byte;
    logic  rx_err;

    // spi master
    logic  spi_start;
    byte_t spi_tx_byte;
    logic  spi_busy;
    logic  spi_done;
    byte_t spi_rx_byte;

    cmd_parser u_parser (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .usb_data_i     (usb_data_i),
        .usb_valid_i    (usb_valid_i),
        .upload_data_o  (upload_data_o),
        .upload_valid_o (upload_valid_o),
        .dac_data_o     (dac_data_o),
        .debug_o        (debug_o),
        .duty_we_o      (duty_we),
        .duty_chan_o    (duty_chan),
        .duty_val_o     (duty_val),
        .tx_start_o     (tx_start),
        .tx_byte_o      (tx_byte),
        .tx_busy_i      (tx_busy),
        .spi_start_o    (spi_start),
        .spi_tx_byte_o  (spi_tx_byte),
        .spi_busy_i     (spi_busy),
        .spi_done_i     (spi_done),
        .spi_rx_byte_i  (spi_rx_byte),
        .rx_valid_i     (rx_valid),
        .rx_byte_i      (rx_byte),
        .rx_err_i       (rx_err)
    );

    pwm_bank u_pwm (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .duty_we_i   (duty_we),
        .duty_chan_i (duty_chan),
        .duty_val_i  (duty_val),
        .pwm_o       (pwm_o)
    );

    uart_bridge u_uart (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_busy_o  (tx_busy),
        .uart_tx_o  (uart_tx_o),
        .uart_rx_i  (uart_rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte),
        .rx_err_o   (rx_err)
    );

    spi_master u_spi (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (spi_start),
        .tx_byte_i  (spi_tx_byte),
        .busy_o     (spi_busy),
        .done_o     (spi_done),
        .rx_byte_o  (spi_rx_byte),
        .spi_clk_o  (spi_clk_o),
        .spi_cs_n_o (spi_cs_n_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

// File: bench/cdc_assertions.sv
module cdc_assertions import cdc_pkg::*; (
    input logic      clk,
    input logic      rst_n_i,
    input logic      usb_valid_i,
    input logic      spi_clk_i,
    input logic      spi_cs_n_i,
    input logic      uart_tx_i,
    input dac_code_t dac_data_i
);

    // no spi clock while the slave is deselected
    spi_clk_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        spi_cs_n_i |-> !spi_clk_i)
        else $error("spi_clk_o high while spi_cs_n_o is high");

    // dac code only moves on the edge that takes a usb byte
    dac_update: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$stable(dac_data_i) |-> $past(usb_valid_i))
        else $error("dac_data_o changed without an accepted usb byte");

    uart_tx_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(uart_tx_i))
        else $error("uart_tx_o is unknown");

endmodule

bind cdc_ctrl_top cdc_assertions cdc_assertions_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .usb_valid_i (usb_valid_i),
    .spi_clk_i   (spi_clk_o),
    .spi_cs_n_i  (spi_cs_n_o),
    .uart_tx_i   (uart_tx_o),
    .dac_data_i  (dac_data_o)
);

// File: bench/cdc_tb.sv
`include "cdc_defines.svh"

module cdc_tb import cdc_pkg::*; ();

    logic                   clk;
    logic                   rst_n_i;
    byte_t                  usb_data_i;
    logic                   usb_valid_i;
    byte_t                  upload_data_o;
    logic                   upload_valid_o;
    logic [`CDC_PWM_CH-1:0] pwm_o;
    logic                   uart_rx_i;
    logic                   uart_tx_o;
    logic                   spi_clk_o;
    logic                   spi_cs_n_o;
    logic                   spi_mosi_o;
    logic                   spi_miso_i;
    dac_code_t              dac_data_o;
    logic                   debug_o;

    int          errors;
    int          checks;
    int          tests;
    int          pwm_high [`CDC_PWM_CH];
    logic [31:0] lfsr_q;
    byte_t       slave_tx;
    byte_t       slave_sh;
    byte_t       slave_rx;

    cdc_ctrl_top cdc_ctrl_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .usb_data_i     (usb_data_i),
        .usb_valid_i    (usb_valid_i),
        .upload_data_o  (upload_data_o),
        .upload_valid_o (upload_valid_o),
        .pwm_o          (pwm_o),
        .uart_rx_i      (uart_rx_i),
        .uart_tx_o      (uart_tx_o),
        .spi_clk_o      (spi_clk_o),
        .spi_cs_n_o     (spi_cs_n_o),
        .spi_mosi_o     (spi_mosi_o),
        .spi_miso_i     (spi_miso_i),
        .dac_data_o     (dac_data_o),
        .debug_o        (debug_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ==================================================
    // spi slave model, mode 0
    // ==================================================
    initial begin
        spi_miso_i = 1'b0;
        slave_sh   = '0;
        slave_rx   = '0;
        forever begin
            @(negedge spi_cs_n_o);
            #1;
            slave_sh   = slave_tx;
            spi_miso_i = slave_tx[7];
            for (int i = 0; i < 8; i++) begin
                // capture on rising, shift on falling
                @(posedge spi_clk_o);
                slave_rx = {slave_rx[6:0], spi_mosi_o};
                @(negedge spi_clk_o);
                #1;
                slave_sh   = slave_sh << 1;
                spi_miso_i = slave_sh[7];
            end
        end
    end

    // ==================================================
    // helpers
    // ==================================================
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b      = {b[6:0], lfsr_q[0]};
        end
        return b;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch at time %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout at time %0t while waiting for %s", $time, what);
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s finished with %0d errors", name, errors - err0);
    endtask

    // drive point is one unit after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input byte_t b);
        usb_data_i  = b;
        usb_valid_i = 1'b1;
        tick();
        usb_valid_i = 1'b0;
    endtask

    task automatic wait_upload(input int limit, output byte_t b, output logic seen);
        int n;
        n    = 0;
        b    = '0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            tick();
            n++;
            if (upload_valid_o) begin
                seen = 1'b1;
                b    = upload_data_o;
            end
        end
        if (!seen) begin
            report_timeout("upload_valid_o");
        end
    endtask

    // samples each uart bit near its middle
    task automatic uart_decode(output byte_t b, output logic stop);
        int n;
        n    = 0;
        b    = '0;
        stop = 1'b0;
        while (uart_tx_o && n < 64) begin
            tick();
            n++;
        end
        if (uart_tx_o) begin
            report_timeout("uart_tx_o start bit");
        end else begin
            repeat (`CDC_UART_DIV / 2) tick();
            for (int i = 0; i < 8; i++) begin
                repeat (`CDC_UART_DIV) tick();
                b[i] = uart_tx_o;
            end
            repeat (`CDC_UART_DIV) tick();
            stop = uart_tx_o;
        end
    endtask

    task automatic uart_drive(input byte_t b, input logic stop);
        uart_rx_i = 1'b0;
        repeat (`CDC_UART_DIV) tick();
        for (int i = 0; i < 8; i++) begin
            uart_rx_i = b[i];
            repeat (`CDC_UART_DIV) tick();
        end
        uart_rx_i = stop;
        repeat (`CDC_UART_DIV) tick();
        uart_rx_i = 1'b1;
    endtask

    task automatic count_pwm();
        for (int c = 0; c < `CDC_PWM_CH; c++) begin
            pwm_high[c] = 0;
        end
        repeat (256) begin
            tick();
            for (int c = 0; c < `CDC_PWM_CH; c++) begin
                if (pwm_o[c]) begin
                    pwm_high[c]++;
                end
            end
        end
    endtask

    task automatic check_idle();
        check("upload_valid_o", 32'd0, 32'(upload_valid_o));
        check("debug_o", 32'd0, 32'(debug_o));
        check("uart_tx_o", 32'd1, 32'(uart_tx_o));
        check("spi_cs_n_o", 32'd1, 32'(spi_cs_n_o));
        check("spi_clk_o", 32'd0, 32'(spi_clk_o));
        check("spi_mosi_o", 32'd0, 32'(spi_mosi_o));
        check("pwm_o", 32'd0, 32'(pwm_o));
        check("dac_data_o", 32'd0, 32'(dac_data_o));
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_reset();
        int e0;
        e0      = errors;
        rst_n_i = 1'b0;
        repeat (8) tick();
        check_idle();
        rst_n_i = 1'b1;
        tick();
        check_idle();
        report_test("reset", e0);
    endtask

    task automatic test_pwm();
        int    e0;
        byte_t duty [`CDC_PWM_CH];
        e0 = errors;
        for (int c = 0; c < `CDC_PWM_CH; c++) begin
            duty[c] = '0;
        end
        // channels 0, 3 and 6
        for (int c = 0; c < `CDC_PWM_CH; c += 3) begin
            duty[c] = rand_byte();
            send_byte(`CDC_CMD_PWM);
            send_byte(byte_t'(c));
            send_byte(duty[c]);
        end
        tick();
        tick();
        count_pwm();
        for (int c = 0; c < `CDC_PWM_CH; c++) begin
            check($sformatf("pwm_o[%0d] high cycles", c), 32'(duty[c]), 32'(pwm_high[c]));
        end
        report_test("pwm duty", e0);
    endtask

    task automatic test_uart_tx();
        int    e0;
        byte_t b;
        byte_t got;
        logic  stop;
        e0 = errors;
        b  = rand_byte();
        send_byte(`CDC_CMD_UART);
        send_byte(b);
        uart_decode(got, stop);
        check("uart_tx_o data", 32'(b), 32'(got));
        check("uart_tx_o stop bit", 32'd1, 32'(stop));
        repeat (`CDC_UART_DIV) tick();
        report_test("uart transmit", e0);
    endtask

    task automatic test_uart_rx();
        int    e0;
        int    ups;
        int    dbg;
        byte_t b;
        byte_t got;
        logic  seen;
        e0 = errors;
        b  = rand_byte();
        uart_drive(b, 1'b1);
        wait_upload(40, got, seen);
        if (seen) begin
            check("upload_data_o", 32'(b), 32'(got));
        end
        // framing error, stop bit low
        b   = rand_byte();
        ups = 0;
        dbg = 0;
        uart_drive(b, 1'b0);
        repeat (40) begin
            tick();
            if (upload_valid_o) begin
                ups++;
            end
            if (debug_o) begin
                dbg++;
            end
        end
        check("upload_valid_o pulses after bad stop bit", 32'd0, 32'(ups));
        check("debug_o pulses after bad stop bit", 32'd1, 32'(dbg));
        report_test("uart receive", e0);
    endtask

    task automatic test_spi();
        int    e0;
        int    n;
        byte_t b;
        byte_t got;
        logic  seen;
        e0       = errors;
        n        = 0;
        slave_tx = rand_byte();
        b        = rand_byte();
        send_byte(`CDC_CMD_SPI);
        send_byte(b);
        while (spi_cs_n_o && n < 4) begin
            tick();
            n++;
        end
        if (spi_cs_n_o) begin
            report_timeout("spi_cs_n_o low");
        end
        wait_upload(16 * `CDC_SPI_DIV + 16, got, seen);
        check("spi slave received byte", 32'(b), 32'(slave_rx));
        if (seen) begin
            check("upload_data_o", 32'(slave_tx), 32'(got));
        end
        check("spi_cs_n_o after exchange", 32'd1, 32'(spi_cs_n_o));
        report_test("spi exchange", e0);
    endtask

    task automatic test_dac_err();
        int    e0;
        int    lows;
        byte_t hi;
        byte_t lo;
        byte_t b;
        byte_t got;
        logic  stop;
        e0 = errors;
        hi = rand_byte();
        lo = rand_byte();
        send_byte(`CDC_CMD_DAC);
        send_byte(hi);
        send_byte(lo);
        check("dac_data_o", 32'({hi[5:0], lo}), 32'(dac_data_o));

        // unknown command, parser must stay in idle
        send_byte(8'hA5);
        check("debug_o after unknown command", 32'd1, 32'(debug_o));
        b = rand_byte();
        send_byte(`CDC_CMD_PWM);
        send_byte(8'd7);
        send_byte(b);
        tick();
        tick();
        count_pwm();
        check("pwm_o[7] high cycles", 32'(b), 32'(pwm_high[7]));

        // second uart command hits a busy transmitter
        b = rand_byte();
        send_byte(`CDC_CMD_UART);
        send_byte(b);
        send_byte(`CDC_CMD_UART);
        send_byte(rand_byte());
        check("debug_o after busy uart command", 32'd1, 32'(debug_o));
        uart_decode(got, stop);
        check("uart_tx_o data", 32'(b), 32'(got));
        check("uart_tx_o stop bit", 32'd1, 32'(stop));
        lows = 0;
        repeat (3 * `CDC_UART_DIV) begin
            tick();
            if (!uart_tx_o) begin
                lows++;
            end
        end
        check("uart_tx_o low cycles after first frame", 32'd0, 32'(lows));
        report_test("dac and errors", e0);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        lfsr_q      = 32'd89171;
        slave_tx    = '0;
        rst_n_i     = 1'b0;
        usb_data_i  = '0;
        usb_valid_i = 1'b0;
        uart_rx_i   = 1'b1;

        test_reset();
        test_pwm();
        test_uart_tx();
        test_uart_rx();
        test_spi();
        test_dac_err();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/cdc_pkg.sv
design/cmd_parser.sv
design/pwm_bank.sv
design/uart_bridge.sv
design/spi_master.sv
design/cdc_ctrl_top.sv
bench/cdc_assertions.sv
bench/cdc_tb.sv

// File: Makefile
SIM      = verilator
TOP      = cdc_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing -Wall
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors
FAIL_MSG = Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
